//--- logic/mem_pkg.sv
// address map widths, bank layout and read source encoding
// bus owner and I/O register enums
package mem_pkg;

    localparam int bus_addr_w  = 32;            // core address bus
    localparam int ram_addr_w  = 17;            // 128 KiB
    localparam int bank_cnt    = 4;
    localparam int bank_sel_w  = $clog2(bank_cnt);
    localparam int bank_addr_w = ram_addr_w - bank_sel_w;   // 15 bits per bank

    // bits 17:16 of the bus address
    localparam logic [1:0] io_region = 2'b11;

    // registered read source: bank number, then io flag, then host flag
    localparam int src_io_bit   = bank_sel_w;
    localparam int src_host_bit = bank_sel_w + 1;
    localparam int src_sel_w    = bank_sel_w + 2;

    typedef enum logic
    {
        owner_cpu  = 1'b0,
        owner_host = 1'b1
    } bus_owner_t;

    // low address bits inside the io region
    typedef enum logic [2:0]
    {
        io_data   = 3'd0,  // tx on write, rx byte on read
        io_status = 3'd4   // bit 0 is rx pending
    } io_reg_t;

endpackage

//--- logic/bus_arbiter.sv
// reset synchronizer, bus owner register and core/host request mux
`timescale 1ns/1ps

module bus_arbiter
    import mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  btnC,
    input  logic                  host_active,
    input  logic                  host_req,
    input  logic                  host_wr,
    input  logic [ram_addr_w-1:0] host_addr,
    input  logic [7:0]            host_wdata,
    input  logic [bus_addr_w-1:0] cpu_addr,
    input  logic                  cpu_wr,
    input  logic [7:0]            cpu_dout,
    output logic                  rst,
    output bus_owner_t            owner,
    output logic                  cpu_rdy,
    output logic                  led,
    output logic [bus_addr_w-1:0] g_addr,
    output logic                  g_wr,
    output logic [7:0]            g_wdata,
    output logic                  g_valid
);

    logic rst_meta;

    // two flop synchronizer, asserts at once and releases on the second edge
    always_ff @(posedge clk or posedge btnC)
    begin
        if (btnC)
        begin
            rst_meta <= 1'b1;
            rst      <= 1'b1;
        end
        else
        begin
            rst_meta <= 1'b0;
            rst      <= rst_meta;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            owner <= owner_cpu;
        else
            owner <= host_active ? owner_host : owner_cpu;  // one cycle behind the level
    end

    assign cpu_rdy = (owner == owner_cpu) && !rst;
    assign led     = (owner == owner_host);

    always_comb
    begin
        if (owner == owner_cpu)
        begin
            g_addr  = cpu_addr;
            g_wr    = cpu_wr;
            g_wdata = cpu_dout;
            g_valid = 1'b1;                     // core presents an access every cycle
        end
        else
        begin
            g_addr  = {{(bus_addr_w - ram_addr_w){1'b0}}, host_addr};
            g_wr    = host_wr && host_req;
            g_wdata = host_wdata;
            g_valid = host_req;
        end
    end

    // a write edge across an owner change must still come with a granted access
    a_wr_needs_valid: assert property (@(posedge clk) disable iff (rst)
        $rose(g_wr) |-> g_valid);

endmodule

//--- logic/addr_decoder.sv
// address decode into bank strobes or an io access
// plus the registered read source for the return path
`timescale 1ns/1ps

module addr_decoder
    import mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [bus_addr_w-1:0]  g_addr,
    input  logic                   g_wr,
    input  logic [7:0]             g_wdata,
    input  logic                   g_valid,
    input  bus_owner_t             owner,
    output logic [bank_cnt-1:0]    bank_en,
    output logic [bank_cnt-1:0]    bank_we,
    output logic [bank_addr_w-1:0] bank_addr,
    output logic [7:0]             bank_wdata,
    output logic                   io_en,
    output logic                   io_wr,
    output io_reg_t                io_sel,
    output logic [7:0]             io_wdata,
    output logic [src_sel_w-1:0]   src_sel
);

    logic is_io;
    logic ram_hit;

    assign is_io   = (g_addr[ram_addr_w -: 2] == io_region);
    assign ram_hit = g_valid && !is_io;

    // low bits pick the bank, the rest is the word inside it
    always_comb
    begin
        bank_en = '0;
        bank_en[g_addr[bank_sel_w-1:0]] = ram_hit;
    end

    assign bank_we    = bank_en & {bank_cnt{g_wr}};
    assign bank_addr  = g_addr[ram_addr_w-1:bank_sel_w];
    assign bank_wdata = g_wdata;

    assign io_en    = g_valid && is_io;
    assign io_wr    = io_en && g_wr;
    assign io_sel   = io_reg_t'(g_addr[2:0]);   // unnamed codes read as zero
    assign io_wdata = g_wdata;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            src_sel <= '0;
        else
        begin
            src_sel[bank_sel_w-1:0] <= g_addr[bank_sel_w-1:0];
            src_sel[src_io_bit]     <= is_io;
            src_sel[src_host_bit]   <= g_valid && !g_wr && (owner == owner_host);
        end
    end

    a_one_bank: assert property (@(posedge clk) disable iff (rst)
        $onehot0(bank_en));

endmodule

//--- logic/ram_bank.sv
// one byte wide bank of the interleaved RAM
// synchronous read, old data returned on a write
`timescale 1ns/1ps

module ram_bank
    import mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   en,
    input  logic                   we,
    input  logic [bank_addr_w-1:0] addr,
    input  logic [7:0]             wdata,
    output logic [7:0]             rdata
);

    logic [7:0] mem [2**bank_addr_w];

    always_ff @(posedge clk)
    begin
        if (en)
        begin
            rdata <= mem[addr];         // read before write
            if (we)
                mem[addr] <= wdata;
        end
    end

endmodule

//--- logic/io_port.sv
// memory mapped io: tx character strobe, rx byte buffer, status
`timescale 1ns/1ps

module io_port
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       io_en,
    input  logic       io_wr,
    input  io_reg_t    io_sel,
    input  logic [7:0] io_wdata,
    input  logic       rx_valid,
    input  logic [7:0] rx_data,
    output logic [7:0] io_rdata,
    output logic       tx_valid,
    output logic [7:0] tx_data
);

    logic       tx_wr;
    logic       data_rd;
    logic       rx_pend;
    logic [7:0] rx_byte;

    assign tx_wr   = io_wr && (io_sel == io_data);
    assign data_rd = io_en && !io_wr && (io_sel == io_data);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tx_valid <= 1'b0;
            rx_pend  <= 1'b0;
        end
        else
        begin
            tx_valid <= tx_wr;
            if (rx_valid)
                rx_pend <= 1'b1;        // a new byte beats a clearing read
            else if (data_rd)
                rx_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (tx_wr)
            tx_data <= io_wdata;
        if (rx_valid)
            rx_byte <= rx_data;
        if (io_en && !io_wr)
        begin
            case (io_sel)
                io_data:   io_rdata <= rx_byte;
                io_status: io_rdata <= {7'b0, rx_pend};
                default:   io_rdata <= 8'h00;
            endcase
        end
    end

    // two data writes in a row would merge into one long pulse
    a_tx_pulse: assert property (@(posedge clk) disable iff (rst)
        tx_valid |=> !tx_valid);

endmodule

//--- logic/read_mux.sv
// read data return path to the core and the host
`timescale 1ns/1ps

module read_mux
    import mem_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic [src_sel_w-1:0]          src_sel,
    input  logic [bank_cnt-1:0][7:0]      bank_rdata,
    input  logic [7:0]                    io_rdata,
    output logic [7:0]                    cpu_din,
    output logic [7:0]                    host_rdata,
    output logic                          host_rvalid
);

    logic [7:0] rd_byte;
    logic [7:0] host_hold;

    // source chosen one cycle ago by the decoder
    always_comb
    begin
        if (src_sel[src_io_bit])
            rd_byte = io_rdata;
        else
            rd_byte = bank_rdata[src_sel[bank_sel_w-1:0]];
    end

    assign cpu_din     = rd_byte;
    assign host_rvalid = src_sel[src_host_bit];

    // host sees its last byte until the next read returns
    always_ff @(posedge clk)
    begin
        if (host_rvalid)
            host_hold <= rd_byte;
    end

    assign host_rdata = host_rvalid ? rd_byte : host_hold;

    // host address is zero extended upstream, so its reads never hit io
    a_host_rd: assert property (@(posedge clk) disable iff (rst)
        host_rvalid |-> !src_sel[src_io_bit]);

endmodule

//--- logic/soc_top.sv
// memory and io subsystem top: arbiter, decoder, ram banks, io, read mux
`timescale 1ns/1ps

module soc_top
    import mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  btnC,
    input  logic [bus_addr_w-1:0] cpu_addr,
    input  logic                  cpu_wr,
    input  logic [7:0]            cpu_dout,
    output logic [7:0]            cpu_din,
    output logic                  cpu_rdy,
    input  logic                  host_active,
    input  logic                  host_req,
    input  logic                  host_wr,
    input  logic [ram_addr_w-1:0] host_addr,
    input  logic [7:0]            host_wdata,
    output logic [7:0]            host_rdata,
    output logic                  host_rvalid,
    input  logic                  rx_valid,
    input  logic [7:0]            rx_data,
    output logic                  tx_valid,
    output logic [7:0]            tx_data,
    output logic                  led
);

    logic                     rst;
    bus_owner_t               owner;
    logic [bus_addr_w-1:0]    g_addr;
    logic                     g_wr;
    logic [7:0]               g_wdata;
    logic                     g_valid;
    logic [bank_cnt-1:0]      bank_en;
    logic [bank_cnt-1:0]      bank_we;
    logic [bank_addr_w-1:0]   bank_addr;
    logic [7:0]               bank_wdata;
    logic [bank_cnt-1:0][7:0] bank_rdata;
    logic                     io_en;
    logic                     io_wr;
    io_reg_t                  io_sel;
    logic [7:0]               io_wdata;
    logic [7:0]               io_rdata;
    logic [src_sel_w-1:0]     src_sel;

    bus_arbiter u_arbiter (
        .clk(clk), .btnC(btnC), .host_active(host_active), .host_req(host_req),
        .host_wr(host_wr), .host_addr(host_addr), .host_wdata(host_wdata),
        .cpu_addr(cpu_addr), .cpu_wr(cpu_wr), .cpu_dout(cpu_dout),
        .rst(rst), .owner(owner), .cpu_rdy(cpu_rdy), .led(led),
        .g_addr(g_addr), .g_wr(g_wr), .g_wdata(g_wdata), .g_valid(g_valid)
    );

    addr_decoder u_decoder (
        .clk(clk), .rst(rst), .g_addr(g_addr), .g_wr(g_wr), .g_wdata(g_wdata),
        .g_valid(g_valid), .owner(owner), .bank_en(bank_en), .bank_we(bank_we),
        .bank_addr(bank_addr), .bank_wdata(bank_wdata), .io_en(io_en), .io_wr(io_wr),
        .io_sel(io_sel), .io_wdata(io_wdata), .src_sel(src_sel)
    );

    for (genvar i = 0; i < bank_cnt; i++)
    begin : bank_gen
        ram_bank u_bank (
            .clk(clk), .en(bank_en[i]), .we(bank_we[i]), .addr(bank_addr),
            .wdata(bank_wdata), .rdata(bank_rdata[i])
        );
    end

    io_port u_io (
        .clk(clk), .rst(rst), .io_en(io_en), .io_wr(io_wr), .io_sel(io_sel),
        .io_wdata(io_wdata), .rx_valid(rx_valid), .rx_data(rx_data),
        .io_rdata(io_rdata), .tx_valid(tx_valid), .tx_data(tx_data)
    );

    read_mux u_rmux (
        .clk(clk), .rst(rst), .src_sel(src_sel), .bank_rdata(bank_rdata),
        .io_rdata(io_rdata), .cpu_din(cpu_din), .host_rdata(host_rdata),
        .host_rvalid(host_rvalid)
    );

endmodule

//--- dv/soc_tb.sv
// testbench for soc_top: xorshift stimulus, RAM and rx buffer model,
// bus owner tracking, per-test report and closing counts
`timescale 1ns/1ps

module soc_tb
    import mem_pkg::*;
();

    localparam int n_core_ops  = 160;
    localparam int n_host_ops  = 80;
    localparam int n_share     = 16;
    localparam int n_chars     = 4;
    localparam int test_cycles = 60 + 2 * n_core_ops + 4 * n_host_ops + 10 * n_share
                                 + 4 * n_chars;
    localparam int cycle_limit = 4 * test_cycles;

    localparam logic [31:0] io_data_addr = 32'h0003_0000;
    localparam logic [31:0] io_stat_addr = 32'h0003_0004;
    localparam logic [31:0] idle_addr    = 32'h0000_0000;   // plain RAM read, no side effect

    logic                  clk;
    logic                  btnC;
    logic [31:0]           cpu_addr;
    logic                  cpu_wr;
    logic [7:0]            cpu_dout;
    logic [7:0]            cpu_din;
    logic                  cpu_rdy;
    logic                  host_active;
    logic                  host_req;
    logic                  host_wr;
    logic [ram_addr_w-1:0] host_addr;
    logic [7:0]            host_wdata;
    logic [7:0]            host_rdata;
    logic                  host_rvalid;
    logic                  rx_valid;
    logic [7:0]            rx_data;
    logic                  tx_valid;
    logic [7:0]            tx_data;
    logic                  led;

    // reference model
    logic [7:0]            mem_m [2**ram_addr_w];
    logic [ram_addr_w-1:0] wr_q [$];        // addresses with known contents
    logic [7:0]            rx_byte_m;
    logic                  rx_pend_m;
    bus_owner_t            owner_m;

    logic [31:0]           rng;
    logic [bank_cnt-1:0]   banks_seen;
    int                    cycles = 0;
    int                    check_cnt = 0;
    int                    err_cnt = 0;
    int                    test_checks = 0;
    int                    test_errs = 0;

    soc_top uut (
        .clk(clk), .btnC(btnC), .cpu_addr(cpu_addr), .cpu_wr(cpu_wr), .cpu_dout(cpu_dout),
        .cpu_din(cpu_din), .cpu_rdy(cpu_rdy), .host_active(host_active),
        .host_req(host_req), .host_wr(host_wr), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_rdata(host_rdata), .host_rvalid(host_rvalid),
        .rx_valid(rx_valid), .rx_data(rx_data), .tx_valid(tx_valid), .tx_data(tx_data),
        .led(led)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [ram_addr_w-1:0] pick_written();
        logic [31:0] r;
        r = next_rand();
        return wr_q[r % wr_q.size()];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("error: %s got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, check_cnt - test_checks,
                 err_cnt - test_errs);
        test_checks = check_cnt;
        test_errs   = err_cnt;
    endtask

    // one granted cycle, then back to idle; lands in RAM only if the core owns the bus
    task automatic core_write(input logic [31:0] addr, input logic [7:0] data);
        @(posedge clk);
        cpu_addr <= addr;
        cpu_wr   <= 1'b1;
        cpu_dout <= data;
        @(posedge clk);
        cpu_addr <= idle_addr;
        cpu_wr   <= 1'b0;
        if (owner_m == owner_cpu && addr[17:16] != io_region)
        begin
            mem_m[addr[ram_addr_w-1:0]] = data;
            wr_q.push_back(addr[ram_addr_w-1:0]);
        end
    endtask

    task automatic core_read(input logic [31:0] addr, input logic [7:0] exp);
        @(posedge clk);
        cpu_addr <= addr;
        cpu_wr   <= 1'b0;
        @(posedge clk);
        cpu_addr <= idle_addr;
        @(negedge clk);                     // byte is back in the next cycle
        check("cpu_din", 32'(cpu_din), 32'(exp));
    endtask

    task automatic host_write(input logic [ram_addr_w-1:0] addr, input logic [7:0] data);
        @(posedge clk);
        host_req   <= 1'b1;
        host_wr    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= data;
        @(posedge clk);
        host_req <= 1'b0;
        host_wr  <= 1'b0;
        @(negedge clk);
        check("host_rvalid", 32'(host_rvalid), 32'h0);
        if (owner_m == owner_host)          // strobes are dropped while the core owns
        begin
            mem_m[addr] = data;
            wr_q.push_back(addr);
        end
    endtask

    task automatic host_read(input logic [ram_addr_w-1:0] addr);
        @(posedge clk);
        host_req  <= 1'b1;
        host_wr   <= 1'b0;
        host_addr <= addr;
        @(posedge clk);
        host_req <= 1'b0;
        @(negedge clk);
        check("host_rvalid", 32'(host_rvalid), 32'h1);
        check("host_rdata", 32'(host_rdata), 32'(mem_m[addr]));
    endtask

    task automatic rx_strobe(input logic [7:0] data);
        @(posedge clk);
        rx_valid <= 1'b1;
        rx_data  <= data;
        @(posedge clk);
        rx_valid  <= 1'b0;
        rx_byte_m = data;
        rx_pend_m = 1'b1;
    endtask

    // owner follows host_active one cycle later
    task automatic switch_owner(input logic to_host);
        @(posedge clk);
        host_active <= to_host;
        @(negedge clk);
        check("cpu_rdy", 32'(cpu_rdy), 32'(owner_m == owner_cpu));
        owner_m = to_host ? owner_host : owner_cpu;
        @(negedge clk);
        check("cpu_rdy", 32'(cpu_rdy), 32'(owner_m == owner_cpu));
        check("led", 32'(led), 32'(owner_m == owner_host));
    endtask

    initial
    begin
        logic [31:0]           r;
        logic [ram_addr_w-1:0] a;
        logic [ram_addr_w-1:0] share_q [$];

        rng         = 32'h25d28fdd;
        btnC        = 1'b1;
        cpu_addr    = idle_addr;
        cpu_wr      = 1'b0;
        cpu_dout    = 8'h00;
        host_active = 1'b0;
        host_req    = 1'b0;
        host_wr     = 1'b0;
        host_addr   = '0;
        host_wdata  = 8'h00;
        rx_valid    = 1'b0;
        rx_data     = 8'h00;
        owner_m     = owner_cpu;
        rx_byte_m   = 8'h00;
        rx_pend_m   = 1'b0;
        banks_seen  = '0;

        repeat (7) @(posedge clk);
        @(negedge clk);
        check("cpu_rdy", 32'(cpu_rdy), 32'h0);
        check("tx_valid", 32'(tx_valid), 32'h0);
        check("host_rvalid", 32'(host_rvalid), 32'h0);
        @(posedge clk);
        btnC <= 1'b0;                       // eighth edge with reset held
        while (cpu_rdy !== 1'b1)
            @(negedge clk);
        check("tx_valid", 32'(tx_valid), 32'h0);
        check("host_rvalid", 32'(host_rvalid), 32'h0);
        check("led", 32'(led), 32'h0);
        end_test("reset");

        for (int i = 0; i < n_core_ops; i++)
        begin
            r = next_rand();
            if (wr_q.size() < 8 || r[0])
            begin
                a = {r[16:2], 2'(i)};       // walk the banks in turn
                core_write(32'(a), r[31:24]);
            end
            else
            begin
                a = pick_written();
                banks_seen[a[1:0]] = 1'b1;
                core_read(32'(a), mem_m[a]);
            end
        end
        check("banks_seen", 32'(banks_seen), 32'hf);
        end_test("core ram access");

        switch_owner(1'b1);
        for (int i = 0; i < n_host_ops; i++)
        begin
            r = next_rand();
            a = pick_written();
            core_write(32'(a), r[15:8]);    // must not reach RAM
            if (r[0])
                host_write(r[31:15], r[7:0]);
            else
                host_read(a);               // byte the core just tried to overwrite
        end
        end_test("host takeover");

        for (int i = 0; i < n_share; i++)
        begin
            r = next_rand();
            host_write(r[16:0], r[31:24]);
            share_q.push_back(r[16:0]);
        end
        switch_owner(1'b0);
        foreach (share_q[i])
            core_read(32'(share_q[i]), mem_m[share_q[i]]);
        a = share_q[0];
        host_write(a, ~mem_m[a]);           // core owns, so the old byte stays
        core_read(32'(a), mem_m[a]);
        share_q = {};
        for (int i = 0; i < n_share; i++)
        begin
            r = next_rand();
            core_write(32'(r[16:0]), r[31:24]);
            share_q.push_back(r[16:0]);
        end
        switch_owner(1'b1);
        foreach (share_q[i])
            host_read(share_q[i]);
        switch_owner(1'b0);
        end_test("shared memory");

        for (int i = 0; i < n_chars; i++)
        begin
            r = next_rand();
            core_write(io_data_addr, r[7:0]);
            @(negedge clk);
            check("tx_valid", 32'(tx_valid), 32'h1);
            check("tx_data", 32'(tx_data), 32'(r[7:0]));
            @(negedge clk);
            check("tx_valid", 32'(tx_valid), 32'h0);  // single pulse
        end
        end_test("output character");

        core_read(io_stat_addr, {7'b0, rx_pend_m});
        r = next_rand();
        rx_strobe(r[7:0]);
        core_read(io_stat_addr, {7'b0, rx_pend_m});
        core_read(io_data_addr, rx_byte_m);
        rx_pend_m = 1'b0;                   // data read clears pending
        core_read(io_stat_addr, {7'b0, rx_pend_m});
        end_test("receive path");

        $display("total: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- soc_mem.f
logic/mem_pkg.sv
logic/bus_arbiter.sv
logic/addr_decoder.sv
logic/ram_bank.sv
logic/io_port.sv
logic/read_mux.sv
logic/soc_top.sv
dv/soc_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= soc_tb
FILELIST  ?= soc_mem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o sim
	$(BUILD_DIR)/sim | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
